// ==== source/core_ctrl_pkg.sv ====
/*
 * core controller shared definitions
 * FSM states, PC and operand selectors, grouped control buses
 */
`default_nettype none

package core_ctrl_pkg;

  // widths fixed by the ISA and the state count
  localparam int STATE_W  = 3;
  localparam int PC_SEL_W = 3;
  localparam int FW_SEL_W = 2;

  // main controller states
  typedef enum logic [STATE_W-1:0] {
    RESET, BOOT_SET, SLEEP, FIRST_FETCH, DECODE, FLUSH_EX, FLUSH_WB
  } ctrl_state_e;

  // next pc source seen by the fetch stage
  typedef enum logic [PC_SEL_W-1:0] {
    PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION, PC_ERET
  } pc_sel_e;

  // jump opcode class from the decoder
  typedef enum logic [1:0] {
    JUMP_NONE, JUMP_JAL, JUMP_JALR, JUMP_COND
  } jump_kind_e;

  // operand mux source in ID
  typedef enum logic [FW_SEL_W-1:0] {
    SEL_REGFILE, SEL_FW_EX, SEL_FW_WB
  } fw_sel_e;

  typedef struct packed {
    logic       illegal;
    logic       mret;
    logic       uret;
    logic       pipe_flush;
    jump_kind_e jump;
  } dec_info_t;

  // one bit per source operand
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } src_hit_t;

  // destination vs source compares, per producer stage
  typedef struct packed {
    src_hit_t ex;
    src_hit_t wb;
    src_hit_t alu;
  } reg_match_t;

  typedef struct packed {
    logic we_ex;
    logic we_wb;
    logic we_alu_fw;
  } wb_we_t;

  typedef struct packed {
    logic    set;
    pc_sel_e sel;
  } pc_ctrl_t;

  typedef struct packed {
    logic ack;
    logic irq_ack;
    logic save_if;
    logic save_id;
    logic save_branch;
    logic restore_mret;
    logic restore_uret;
  } exc_ctrl_t;

  typedef struct packed {
    fw_sel_e a;
    fw_sel_e b;
    fw_sel_e c;
  } fw_sels_t;

  typedef struct packed {
    logic load;
    logic csr;
    logic jr;
  } stall_t;

endpackage

`default_nettype wire

// ==== source/ctrl_fsm.sv ====
/*
 * main controller FSM
 * boot, sleep, decode, pipeline flush and pc / exception control
 */
`default_nettype none

module ctrl_fsm import core_ctrl_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      fetch_enable_i,
  input  wire logic      instr_valid_i,
  input  wire logic      branch_taken_i,
  input  wire logic      int_req_i,
  input  wire logic      ext_req_i,
  input  wire logic      id_ready_i,
  input  wire logic      ex_valid_i,
  input  wire dec_info_t dec_i,
  input  wire logic      jr_stall_i,
  output pc_ctrl_t       pc_ctrl_o,
  output exc_ctrl_t      exc_ctrl_o,
  output logic           instr_req_o,
  output logic           busy_o,
  output logic           is_decoding_o,
  output logic           halt_if_o,
  output logic           halt_id_o
);

  ctrl_state_e state_q, state_d;
  logic        jump_done_q, jump_done_d;
  logic        exc_req;
  logic        jump_uncond;

  // any pending trap, internal or external
  assign exc_req     = int_req_i | ext_req_i;
  // jal / jalr resolve in ID, conditional ones wait for EX
  assign jump_uncond = (dec_i.jump == JUMP_JAL) || (dec_i.jump == JUMP_JALR);

  //////////////////////////////////////////////////
  // next state and output decode
  //////////////////////////////////////////////////

  always_comb begin
    // defaults for a running core
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    instr_req_o   = 1'b1;
    busy_o        = 1'b1;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    pc_ctrl_o     = '{set: 1'b0, sel: PC_BOOT};
    exc_ctrl_o    = '0;

    unique case (state_q)
      RESET: begin
        // idle until fetch is enabled
        instr_req_o = 1'b0;
        busy_o      = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        // load boot address into the fetch pc
        pc_ctrl_o.set = 1'b1;
        pc_ctrl_o.sel = PC_BOOT;
        state_d       = FIRST_FETCH;
      end

      SLEEP: begin
        // pipeline frozen, wake on enable or trap
        instr_req_o = 1'b0;
        busy_o      = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        // wait out the IF miss
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // a trap here saves the IF pc, pipeline was flushed before sleep
        if (exc_req) begin
          pc_ctrl_o.set      = 1'b1;
          pc_ctrl_o.sel      = PC_EXCEPTION;
          exc_ctrl_o.ack     = 1'b1;
          exc_ctrl_o.irq_ack = ext_req_i;
          exc_ctrl_o.save_if = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i && !branch_taken_i) begin
          is_decoding_o = 1'b1;

          // one pc action per instruction, highest priority first
          if (jump_uncond) begin
            pc_ctrl_o.sel = PC_JUMP;
            // target register may still be in flight
            if (!jr_stall_i && !jump_done_q) begin
              pc_ctrl_o.set = 1'b1;
              jump_done_d   = 1'b1;
            end
          end else if (dec_i.mret) begin
            pc_ctrl_o.sel           = PC_ERET;
            exc_ctrl_o.restore_mret = 1'b1;
            if (!jump_done_q) begin
              pc_ctrl_o.set = 1'b1;
              jump_done_d   = 1'b1;
            end
          end else if (dec_i.uret) begin
            pc_ctrl_o.sel           = PC_ERET;
            exc_ctrl_o.restore_uret = 1'b1;
            if (!jump_done_q) begin
              pc_ctrl_o.set = 1'b1;
              jump_done_d   = 1'b1;
            end
          end else if (int_req_i) begin
            // ecall or illegal, keep it out of EX
            pc_ctrl_o.set      = 1'b1;
            pc_ctrl_o.sel      = PC_EXCEPTION;
            exc_ctrl_o.ack     = 1'b1;
            exc_ctrl_o.save_id = 1'b1;
            halt_id_o          = 1'b1;
          end else if (ext_req_i) begin
            pc_ctrl_o.set      = 1'b1;
            pc_ctrl_o.sel      = PC_EXCEPTION;
            exc_ctrl_o.ack     = 1'b1;
            exc_ctrl_o.irq_ack = 1'b1;
            exc_ctrl_o.save_id = 1'b1;
            halt_id_o          = 1'b1;
          end

          // wfi style flush, also eret with fetch disabled goes back to sleep
          if (dec_i.pipe_flush || ((dec_i.mret || dec_i.uret) && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // empty ID slot, interrupt saves the IF pc instead
        if (!instr_valid_i && !branch_taken_i && ext_req_i) begin
          pc_ctrl_o.set      = 1'b1;
          pc_ctrl_o.sel      = PC_EXCEPTION;
          exc_ctrl_o.ack     = 1'b1;
          exc_ctrl_o.irq_ack = 1'b1;
          exc_ctrl_o.save_if = 1'b1;
          halt_id_o          = 1'b1;
        end

        // taken branch in EX wins over whatever sits in ID
        if (branch_taken_i) begin
          pc_ctrl_o.set = 1'b1;
          pc_ctrl_o.sel = PC_BRANCH;
          if (ext_req_i) begin
            // interrupt lands on the branch target
            pc_ctrl_o.sel          = PC_EXCEPTION;
            exc_ctrl_o.ack         = 1'b1;
            exc_ctrl_o.irq_ack     = 1'b1;
            exc_ctrl_o.save_branch = 1'b1;
            halt_id_o              = 1'b1;
          end
        end
      end

      FLUSH_EX: begin
        // drain EX with a bubble behind it
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      FLUSH_WB: begin
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          state_d = DECODE;
        end else begin
          halt_if_o = 1'b1;
          state_d   = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // held while ID is stalled so the jump fires once
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
/*
 * data hazard stall detection
 * load-use, csr-use and jump-register stalls plus write-enable kill
 */
`default_nettype none

module hazard_unit import core_ctrl_pkg::*; (
  input  wire logic       is_decoding_i,
  input  wire logic       illegal_i,
  input  wire jump_kind_e jump_i,
  input  wire logic       data_req_ex_i,
  input  wire wb_we_t     we_i,
  input  wire reg_match_t match_i,
  input  wire logic       csr_busy_i,
  input  wire logic       csr_access_id_i,
  output stall_t          stall_o,
  output logic            deassert_we_o
);

  logic ex_hit_any;
  logic wb_hit_a;
  logic ex_hit_a;
  logic alu_hit_a;

  //////////////////////////////////////////////////
  // producer matches
  //////////////////////////////////////////////////

  // EX destination feeds any source of the ID instruction
  assign ex_hit_any = match_i.ex.a | match_i.ex.b | match_i.ex.c;

  // only operand a carries the jalr base register
  assign wb_hit_a  = we_i.we_wb & match_i.wb.a;
  assign ex_hit_a  = we_i.we_ex & match_i.ex.a;
  assign alu_hit_a = we_i.we_alu_fw & match_i.alu.a;

  //////////////////////////////////////////////////
  // stall sources
  //////////////////////////////////////////////////

  always_comb begin
    // load data is not back before ID needs it
    stall_o.load = data_req_ex_i & we_i.we_ex & ex_hit_any;

    // csr write in EX, read in ID
    // coarse check, no compare on csr address
    stall_o.csr  = csr_busy_i & csr_access_id_i;

    // jump target goes straight to the pc
    // so no forwarded value may be pending
    stall_o.jr   = (jump_i == JUMP_JALR) & (wb_hit_a | ex_hit_a | alu_hit_a);
  end

  //////////////////////////////////////////////////
  // write-enable suppression
  //////////////////////////////////////////////////

  // bubble into EX whenever ID does not retire cleanly
  assign deassert_we_o = ~is_decoding_i
                       | illegal_i
                       | stall_o.load
                       | stall_o.csr
                       | stall_o.jr;

endmodule

`default_nettype wire

// ==== source/fwd_unit.sv ====
/*
 * operand forwarding select
 * picks regfile, EX or WB result for the three ID source operands
 */
`default_nettype none

module fwd_unit import core_ctrl_pkg::*; (
  input  wire wb_we_t     we_i,
  input  wire reg_match_t match_i,
  input  wire logic       data_misaligned_i,
  input  wire logic       mult_multicycle_i,
  output fw_sels_t        fw_sel_o
);

  // per operand choice, the younger EX result beats WB
  function automatic fw_sel_e pick_src(input logic wb_fw, input logic ex_fw);
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (wb_fw) begin
      sel = SEL_FW_WB;
    end
    if (ex_fw) begin
      sel = SEL_FW_EX;
    end
    return sel;
  endfunction

  always_comb begin
    fw_sel_o.a = pick_src(we_i.we_wb & match_i.wb.a, we_i.we_alu_fw & match_i.alu.a);
    fw_sel_o.b = pick_src(we_i.we_wb & match_i.wb.b, we_i.we_alu_fw & match_i.alu.b);
    fw_sel_o.c = pick_src(we_i.we_wb & match_i.wb.c, we_i.we_alu_fw & match_i.alu.c);

    // second half of a misaligned access
    // address comes back from EX, b is unused
    if (data_misaligned_i) begin
      fw_sel_o.a = SEL_FW_EX;
      fw_sel_o.b = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps partial result on operand c
      fw_sel_o.c = SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

// ==== source/core_ctrl.sv ====
/*
 * core controller top
 * joins the main FSM, hazard stall logic and forwarding select
 */
`default_nettype none

module core_ctrl import core_ctrl_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,

  // decoder and register compare info
  input  wire dec_info_t  dec_i,
  input  wire reg_match_t match_i,
  input  wire wb_we_t     we_i,

  // pipeline and trap status
  input  wire logic       fetch_enable_i,
  input  wire logic       instr_valid_i,
  input  wire logic       branch_taken_i,
  input  wire logic       int_req_i,
  input  wire logic       ext_req_i,
  input  wire logic       id_ready_i,
  input  wire logic       ex_valid_i,
  input  wire logic       data_req_ex_i,
  input  wire logic       data_misaligned_i,
  input  wire logic       mult_multicycle_i,
  input  wire logic       csr_busy_i,
  input  wire logic       csr_access_id_i,

  // fetch, exception and stage control
  output pc_ctrl_t        pc_ctrl_o,
  output exc_ctrl_t       exc_ctrl_o,
  output logic            instr_req_o,
  output logic            busy_o,
  output logic            is_decoding_o,
  output logic            halt_if_o,
  output logic            halt_id_o,

  // stalls and operand select
  output stall_t          stall_o,
  output logic            deassert_we_o,
  output fw_sels_t        fw_sel_o
);

  // jr stall feeds back into the FSM jump handling
  ctrl_fsm i_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid_i),
    .branch_taken_i (branch_taken_i),
    .int_req_i      (int_req_i),
    .ext_req_i      (ext_req_i),
    .id_ready_i     (id_ready_i),
    .ex_valid_i     (ex_valid_i),
    .dec_i          (dec_i),
    .jr_stall_i     (stall_o.jr),
    .pc_ctrl_o      (pc_ctrl_o),
    .exc_ctrl_o     (exc_ctrl_o),
    .instr_req_o    (instr_req_o),
    .busy_o         (busy_o),
    .is_decoding_o  (is_decoding_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o)
  );

  hazard_unit i_hazard_unit (
    .is_decoding_i   (is_decoding_o),
    .illegal_i       (dec_i.illegal),
    .jump_i          (dec_i.jump),
    .data_req_ex_i   (data_req_ex_i),
    .we_i            (we_i),
    .match_i         (match_i),
    .csr_busy_i      (csr_busy_i),
    .csr_access_id_i (csr_access_id_i),
    .stall_o         (stall_o),
    .deassert_we_o   (deassert_we_o)
  );

  fwd_unit i_fwd_unit (
    .we_i              (we_i),
    .match_i           (match_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fw_sel_o          (fw_sel_o)
  );

endmodule

`default_nettype wire

// ==== bench/core_ctrl_assertions.sv ====
/*
 * core controller checks
 * concurrent properties for boot, forwarding, stalls, traps and flush
 */
`default_nettype none

module core_ctrl_assertions import core_ctrl_pkg::*; (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire dec_info_t   dec_i,
  input wire reg_match_t  match_i,
  input wire wb_we_t      we_i,
  input wire logic        fetch_enable_i,
  input wire logic        branch_taken_i,
  input wire logic        int_req_i,
  input wire logic        ext_req_i,
  input wire logic        data_req_ex_i,
  input wire logic        data_misaligned_i,
  input wire logic        mult_multicycle_i,
  input wire logic        csr_busy_i,
  input wire logic        csr_access_id_i,
  input wire pc_ctrl_t    pc_ctrl_o,
  input wire exc_ctrl_t   exc_ctrl_o,
  input wire logic        instr_req_o,
  input wire logic        busy_o,
  input wire logic        is_decoding_o,
  input wire logic        halt_if_o,
  input wire logic        halt_id_o,
  input wire stall_t      stall_o,
  input wire logic        deassert_we_o,
  input wire fw_sels_t    fw_sel_o,
  input wire ctrl_state_e state_i
);

  // bumped by every failing property
  int unsigned fail_cnt = 0;

  fw_sels_t fw_exp;
  stall_t   stall_exp;
  logic     jump_any;

  // ALU result first, then WB, else regfile
  function automatic fw_sel_e expected_src(input logic wb_hit, input logic alu_hit);
    if (alu_hit) begin
      return SEL_FW_EX;
    end else if (wb_hit) begin
      return SEL_FW_WB;
    end
    return SEL_REGFILE;
  endfunction

  //////////////////////////////////////////////////
  // reference values
  //////////////////////////////////////////////////

  always_comb begin
    fw_exp.a = expected_src(match_i.wb.a && we_i.we_wb, match_i.alu.a && we_i.we_alu_fw);
    fw_exp.b = expected_src(match_i.wb.b && we_i.we_wb, match_i.alu.b && we_i.we_alu_fw);
    fw_exp.c = expected_src(match_i.wb.c && we_i.we_wb, match_i.alu.c && we_i.we_alu_fw);
    if (data_misaligned_i) begin
      fw_exp.a = SEL_FW_EX;
      fw_exp.b = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      fw_exp.c = SEL_FW_EX;
    end

    // load in EX against any source
    stall_exp.load = data_req_ex_i && we_i.we_ex && (match_i.ex != 3'b000);
    stall_exp.csr  = csr_busy_i && csr_access_id_i;
    // jalr base register still in flight
    stall_exp.jr   = (dec_i.jump == JUMP_JALR)
                   && ((match_i.wb.a && we_i.we_wb)
                   || (match_i.ex.a && we_i.we_ex)
                   || (match_i.alu.a && we_i.we_alu_fw));
  end

  // jal and jalr take the pc in ID
  assign jump_any = (dec_i.jump == JUMP_JAL) || (dec_i.jump == JUMP_JALR);

  //////////////////////////////////////////////////
  // boot and idle
  //////////////////////////////////////////////////

  // controller parked in reset with fetch disabled
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == RESET && !fetch_enable_i
    |-> !busy_o && !instr_req_o && !pc_ctrl_o.set && exc_ctrl_o == '0
        && !is_decoding_o && !halt_if_o && !halt_id_o)
    else begin
      fail_cnt++;
      $error("Error: idle outputs busy_o %h instr_req_o %h pc_ctrl_o %h exc_ctrl_o %h",
             $sampled(busy_o), $sampled(instr_req_o), $sampled(pc_ctrl_o),
             $sampled(exc_ctrl_o));
    end

  boot_jump: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == RESET && fetch_enable_i |=> pc_ctrl_o.set && pc_ctrl_o.sel == PC_BOOT)
    else begin
      fail_cnt++;
      $error("Error: pc_ctrl_o %h expected %h", $sampled(pc_ctrl_o), {1'b1, PC_BOOT});
    end

  //////////////////////////////////////////////////
  // forwarding and stalls
  //////////////////////////////////////////////////

  fwd_sel: assert property (@(posedge clk) disable iff (!rst_n) fw_sel_o == fw_exp)
    else begin
      fail_cnt++;
      $error("Error: fw_sel_o %h expected %h", fw_sel_o, fw_exp);
    end

  stall_bits: assert property (@(posedge clk) disable iff (!rst_n) stall_o == stall_exp)
    else begin
      fail_cnt++;
      $error("Error: stall_o %h expected %h", stall_o, stall_exp);
    end

  we_kill: assert property (@(posedge clk) disable iff (!rst_n)
    deassert_we_o == (!is_decoding_o || dec_i.illegal || stall_exp != 3'b000))
    else begin
      fail_cnt++;
      $error("Error: deassert_we_o %h is_decoding_o %h", $sampled(deassert_we_o),
             $sampled(is_decoding_o));
    end

  //////////////////////////////////////////////////
  // traps and branches
  //////////////////////////////////////////////////

  id_exception: assert property (@(posedge clk) disable iff (!rst_n)
    is_decoding_o && int_req_i && !jump_any && !dec_i.mret && !dec_i.uret
    |-> pc_ctrl_o.set && pc_ctrl_o.sel == PC_EXCEPTION && exc_ctrl_o.ack
        && exc_ctrl_o.save_id && halt_id_o)
    else begin
      fail_cnt++;
      $error("Error: pc_ctrl_o %h exc_ctrl_o %h halt_id_o %h on exception",
             $sampled(pc_ctrl_o), $sampled(exc_ctrl_o), $sampled(halt_id_o));
    end

  ack_with_pc: assert property (@(posedge clk) disable iff (!rst_n)
    exc_ctrl_o.ack |-> pc_ctrl_o.set && pc_ctrl_o.sel == PC_EXCEPTION)
    else begin
      fail_cnt++;
      $error("Error: pc_ctrl_o %h with exception ack", $sampled(pc_ctrl_o));
    end

  branch_pc: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == DECODE && branch_taken_i
    |-> pc_ctrl_o.set && !is_decoding_o
        && pc_ctrl_o.sel == (ext_req_i ? PC_EXCEPTION : PC_BRANCH))
    else begin
      fail_cnt++;
      $error("Error: pc_ctrl_o %h is_decoding_o %h on taken branch",
             $sampled(pc_ctrl_o), $sampled(is_decoding_o));
    end

  // interrupt resumes at the branch target
  branch_irq: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == DECODE && branch_taken_i && ext_req_i
    |-> exc_ctrl_o.irq_ack && exc_ctrl_o.save_branch)
    else begin
      fail_cnt++;
      $error("Error: exc_ctrl_o %h on branch with interrupt", $sampled(exc_ctrl_o));
    end

  //////////////////////////////////////////////////
  // flush and sleep
  //////////////////////////////////////////////////

  flush_enter: assert property (@(posedge clk) disable iff (!rst_n)
    is_decoding_o && dec_i.pipe_flush |-> halt_if_o && halt_id_o ##1 state_i == FLUSH_EX)
    else begin
      fail_cnt++;
      $error("Error: state_i %h after pipe flush", $sampled(state_i));
    end

  // halts held until EX drains
  flush_hold: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == FLUSH_EX |-> halt_if_o && halt_id_o)
    else begin
      fail_cnt++;
      $error("Error: halt_if_o %h halt_id_o %h while flushing", $sampled(halt_if_o),
             $sampled(halt_id_o));
    end

  sleep_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == SLEEP |-> !busy_o && !instr_req_o)
    else begin
      fail_cnt++;
      $error("Error: busy_o %h instr_req_o %h while sleeping", $sampled(busy_o),
             $sampled(instr_req_o));
    end

endmodule

bind core_ctrl core_ctrl_assertions i_assertions (.*, .state_i(i_ctrl_fsm.state_q));

`default_nettype wire

// ==== bench/tb_core_ctrl.sv ====
/*
 * core controller testbench
 * boot, random pipeline traffic, then flush into sleep and wake again
 */
`default_nettype none

module tb_core_ctrl import core_ctrl_pkg::*; ();

  localparam int          WAIT_LIMIT    = 50;
  localparam int          RANDOM_CYCLES = 3000;
  localparam logic [31:0] LFSR_SEED     = 32'had13d160;
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

  logic       clk;
  logic       rst_n;
  dec_info_t  dec_i;
  reg_match_t match_i;
  wb_we_t     we_i;
  logic       fetch_enable_i;
  logic       instr_valid_i;
  logic       branch_taken_i;
  logic       int_req_i;
  logic       ext_req_i;
  logic       id_ready_i;
  logic       ex_valid_i;
  logic       data_req_ex_i;
  logic       data_misaligned_i;
  logic       mult_multicycle_i;
  logic       csr_busy_i;
  logic       csr_access_id_i;
  pc_ctrl_t   pc_ctrl_o;
  exc_ctrl_t  exc_ctrl_o;
  logic       instr_req_o;
  logic       busy_o;
  logic       is_decoding_o;
  logic       halt_if_o;
  logic       halt_id_o;
  stall_t     stall_o;
  logic       deassert_we_o;
  fw_sels_t   fw_sel_o;

  logic [31:0] lfsr;
  int          timeouts;

  core_ctrl i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////

  // galois step, one call per bit used
  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ LFSR_TAPS;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // high with odds of one in 2**k
  function automatic logic one_in(input int k);
    logic hit;
    int   i;
    hit = 1'b1;
    for (i = 0; i < k; i++) begin
      hit = hit & next_bit();
    end
    return hit;
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // no hazards, no traps, pipeline always ready
  task automatic drive_quiet(input logic fe);
    dec_i             = '0;
    match_i           = '0;
    we_i              = '0;
    fetch_enable_i    = fe;
    instr_valid_i     = 1'b1;
    branch_taken_i    = 1'b0;
    int_req_i         = 1'b0;
    ext_req_i         = 1'b0;
    id_ready_i        = 1'b1;
    ex_valid_i        = 1'b1;
    data_req_ex_i     = 1'b0;
    data_misaligned_i = 1'b0;
    mult_multicycle_i = 1'b0;
    csr_busy_i        = 1'b0;
    csr_access_id_i   = 1'b0;
  endtask

  // fetch enable left as is, flushes and erets kept rare
  task automatic drive_random();
    logic [31:0] r;
    r                 = rand_bits(9);
    match_i           = r[8:0];
    r                 = rand_bits(3);
    we_i              = r[2:0];
    r                 = rand_bits(2);
    dec_i.jump        = jump_kind_e'(r[1:0]);
    dec_i.illegal     = one_in(3);
    dec_i.mret        = one_in(4);
    dec_i.uret        = one_in(4);
    dec_i.pipe_flush  = one_in(4);
    instr_valid_i     = !one_in(2);
    branch_taken_i    = one_in(2);
    int_req_i         = one_in(2);
    ext_req_i         = one_in(2);
    id_ready_i        = !one_in(2);
    ex_valid_i        = one_in(1);
    data_req_ex_i     = one_in(1);
    data_misaligned_i = one_in(3);
    mult_multicycle_i = one_in(3);
    csr_busy_i        = one_in(1);
    csr_access_id_i   = one_in(1);
  endtask

  // outputs sampled on the falling edge before new inputs go out
  task automatic wait_decoding();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!is_decoding_o && n < WAIT_LIMIT);
    if (!is_decoding_o) begin
      timeouts++;
      $display("timeout: controller did not reach decode within %0d cycles", WAIT_LIMIT);
    end
  endtask

  // sleep shows as not busy with fetch halted
  task automatic wait_sleep();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(!busy_o && halt_if_o) && n < WAIT_LIMIT);
    if (busy_o || !halt_if_o) begin
      timeouts++;
      $display("timeout: controller did not go to sleep within %0d cycles", WAIT_LIMIT);
    end
  endtask

  //////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////

  initial begin
    int fails;
    int i;
    fails    = 0;
    timeouts = 0;
    lfsr     = LFSR_SEED;
    rst_n    = 1'b0;
    drive_quiet(1'b0);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle in reset, then boot
    repeat (3) @(negedge clk);
    fetch_enable_i = 1'b1;
    wait_decoding();

    for (i = 0; i < RANDOM_CYCLES; i++) begin
      @(negedge clk);
      drive_random();
    end

    // drain whatever the random traffic left behind
    @(negedge clk);
    drive_quiet(1'b1);
    wait_decoding();

    // wfi style flush with fetch disabled
    dec_i.pipe_flush = 1'b1;
    fetch_enable_i   = 1'b0;
    ex_valid_i       = 1'b0;
    @(negedge clk);
    dec_i.pipe_flush = 1'b0;
    instr_valid_i    = 1'b0;
    repeat (3) @(negedge clk);
    ex_valid_i = 1'b1;
    wait_sleep();

    // stay asleep a while, then wake through fetch enable
    repeat (4) @(negedge clk);
    instr_valid_i  = 1'b1;
    fetch_enable_i = 1'b1;
    wait_decoding();
    repeat (2) @(negedge clk);

    fails = i_dut.i_assertions.fail_cnt;
    $display("checks done: %0d assertion failures, %0d timeouts", fails, timeouts);
    if (fails == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/core_ctrl_pkg.sv
source/ctrl_fsm.sv
source/hazard_unit.sv
source/fwd_unit.sv
source/core_ctrl.sv
bench/core_ctrl_assertions.sv
bench/tb_core_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the core controller testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_core_ctrl
FLIST     := project.f
MDIR      := obj_dir
BIN       := $(MDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) +verilator+error+limit+1000 > $(LOG) 2>&1
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
